// File: compile.f
+incdir+source
source/ex_op_pkg.sv
source/ex_mem_pkg.sv
source/regular_alu.sv
source/div_alu.sv
source/branch_alu.sv
source/mem_agu.sv
source/ex_stage.sv
tb/ex_stage_chk.sv
tb/ex_stage_tb.sv

// File: source/branch_alu.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module branch_alu (
    input  ex_op_pkg::alu_op_e   aluop_i,
    input  logic [`EX_XLEN-1:0]  pc_i,
    input  logic [`EX_XLEN-1:0]  inst_i,
    input  logic [`EX_XLEN-1:0]  reg1_i,
    input  logic [`EX_XLEN-1:0]  reg2_i,
    input  logic                 pre_taken_i,
    input  logic [`EX_XLEN-1:0]  pre_target_i,
    output logic                 taken_o,
    output logic [`EX_XLEN-1:0]  target_o,
    output logic [`EX_XLEN-1:0]  link_o,
    output logic                 flush_o
);

    import ex_op_pkg::*;

    logic [`EX_XLEN-1:0] offs16;
    logic [`EX_XLEN-1:0] offs26;
    logic [`EX_XLEN-1:0] jump_addr;

    // sign-extended word offsets
    assign offs16 = {{(`EX_XLEN-18){inst_i[25]}}, inst_i[25:10], 2'b00};
    assign offs26 = {{(`EX_XLEN-28){inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    assign link_o = pc_i + `EX_XLEN'(4);

    always_comb begin
        jump_addr = pc_i + offs16;
        case (aluop_i)
            ALU_BEQ:  taken_o = (reg1_i == reg2_i);
            ALU_BNE:  taken_o = (reg1_i != reg2_i);
            ALU_BLT:  taken_o = ($signed(reg1_i) < $signed(reg2_i));
            ALU_BGE:  taken_o = ($signed(reg1_i) >= $signed(reg2_i));
            ALU_BLTU: taken_o = (reg1_i < reg2_i);
            ALU_BGEU: taken_o = (reg1_i >= reg2_i);
            ALU_JIRL: begin
                taken_o   = 1'b1;
                jump_addr = reg1_i + offs16;
            end
            ALU_BL: begin
                taken_o   = 1'b1;
                jump_addr = pc_i + offs26;
            end
            default:  taken_o = 1'b0;
        endcase
    end

    // actual next fetch address
    assign target_o = taken_o ? jump_addr : link_o;

    assign flush_o = (taken_o != pre_taken_i) ||
                     (taken_o && pre_taken_i && (jump_addr != pre_target_i));

endmodule

// File: source/div_alu.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module div_alu (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  logic                 signed_i,
    input  logic [`EX_XLEN-1:0]  dividend_i,
    input  logic [`EX_XLEN-1:0]  divisor_i,
    output logic [`EX_XLEN-1:0]  quotient_o,
    output logic [`EX_XLEN-1:0]  remainder_o,
    output logic                 done_o
);

    localparam int CNT_W = $clog2(`EX_DIV_STEPS);
    localparam int MSB   = `EX_XLEN - 1;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_e;

    div_state_e state_q;
    logic [CNT_W-1:0] step_q;

    logic [MSB:0] quo_q;
    logic [MSB:0] rem_q;
    logic [MSB:0] dvs_q;
    logic         neg_quo_q;
    logic         neg_rem_q;
    logic         zero_q;

    logic [MSB:0]   dvd_mag;
    logic [MSB:0]   dvs_mag;
    logic [MSB+1:0] rem_shift;
    logic [MSB+1:0] trial;

    assign dvd_mag = (signed_i && dividend_i[MSB]) ? -dividend_i : dividend_i;
    assign dvs_mag = (signed_i && divisor_i[MSB]) ? -divisor_i : divisor_i;

    // bring in next dividend bit and try subtracting
    assign rem_shift = {rem_q, quo_q[MSB]};
    assign trial     = rem_shift - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_BUSY;
                        step_q  <= '0;
                    end
                end
                DIV_BUSY: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == CNT_W'(`EX_DIV_STEPS - 1)) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && start_i) begin
            quo_q     <= dvd_mag;
            rem_q     <= '0;
            dvs_q     <= dvs_mag;
            neg_quo_q <= signed_i && (dividend_i[MSB] ^ divisor_i[MSB]);
            neg_rem_q <= signed_i && dividend_i[MSB];
            zero_q    <= (divisor_i == '0);
        end else if (state_q == DIV_BUSY) begin
            if (!trial[MSB+1]) begin
                rem_q <= trial[MSB:0];
                quo_q <= {quo_q[MSB-1:0], 1'b1};
            end else begin
                rem_q <= rem_shift[MSB:0];
                quo_q <= {quo_q[MSB-1:0], 1'b0};
            end
        end
    end

    // remainder takes the dividend's sign
    assign quotient_o  = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign remainder_o = neg_rem_q ? -rem_q : rem_q;
    assign done_o      = (state_q == DIV_DONE);

endmodule

// File: source/ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath and address width
`define EX_XLEN 32

// stable counter width read as two words
`define EX_CNT_W 64

// one quotient bit per iteration
`define EX_DIV_STEPS 32

// LL bit control register address
`define EX_CSR_LLBCTL 14'h060

`endif

// File: source/ex_mem_pkg.sv
package ex_mem_pkg;

    // access size of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // ecode values as seen by the exception logic
    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        // address not aligned to access size
        EXC_ALE  = 7'h09
    } exc_cause_e;

endpackage

// File: source/ex_op_pkg.sv
package ex_op_pkg;

    // decoded operation shared by decode ports and all units
    typedef enum logic [5:0] {
        ALU_NOP      = 6'h00,
        ALU_ADD      = 6'h01,
        ALU_SUB      = 6'h02,
        ALU_SLT      = 6'h03,
        ALU_SLTU     = 6'h04,
        ALU_AND      = 6'h05,
        ALU_OR       = 6'h06,
        ALU_NOR      = 6'h07,
        ALU_XOR      = 6'h08,
        ALU_SLL      = 6'h09,
        ALU_SRL      = 6'h0a,
        ALU_SRA      = 6'h0b,
        ALU_LU12I    = 6'h0c,
        ALU_DIVW     = 6'h10,
        ALU_MODW     = 6'h11,
        ALU_DIVWU    = 6'h12,
        ALU_MODWU    = 6'h13,
        ALU_BEQ      = 6'h18,
        ALU_BNE      = 6'h19,
        ALU_BLT      = 6'h1a,
        ALU_BGE      = 6'h1b,
        ALU_BLTU     = 6'h1c,
        ALU_BGEU     = 6'h1d,
        ALU_JIRL     = 6'h1e,
        ALU_BL       = 6'h1f,
        ALU_LDB      = 6'h20,
        ALU_LDBU     = 6'h21,
        ALU_LDH      = 6'h22,
        ALU_LDHU     = 6'h23,
        ALU_LDW      = 6'h24,
        ALU_LLW      = 6'h25,
        ALU_STB      = 6'h28,
        ALU_STH      = 6'h29,
        ALU_STW      = 6'h2a,
        ALU_SCW      = 6'h2b,
        ALU_CSRRD    = 6'h30,
        ALU_CSRWR    = 6'h31,
        ALU_RDCNTVLW = 6'h32,
        ALU_RDCNTVHW = 6'h33
    } alu_op_e;

    // which unit produces the write-back value
    typedef enum logic [2:0] {
        SEL_LOGIC      = 3'd0,
        SEL_SHIFT      = 3'd1,
        SEL_ARITH      = 3'd2,
        SEL_DIV        = 3'd3,
        SEL_BRANCH     = 3'd4,
        SEL_LOAD_STORE = 3'd5,
        SEL_CSR        = 3'd6,
        SEL_NONE       = 3'd7
    } alu_sel_e;

endpackage

// File: source/ex_stage.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     inst_valid_i,
    input  logic [`EX_XLEN-1:0]      pc_i,
    input  logic [`EX_XLEN-1:0]      inst_i,
    input  ex_op_pkg::alu_op_e       aluop_i,
    input  ex_op_pkg::alu_sel_e      alusel_i,
    input  logic [`EX_XLEN-1:0]      reg1_i,
    input  logic [`EX_XLEN-1:0]      reg2_i,
    input  logic                     pre_taken_i,
    input  logic [`EX_XLEN-1:0]      pre_target_i,
    input  logic [`EX_XLEN-1:0]      csr_read_data_i,
    input  logic                     csr_write_en_i,
    input  logic [13:0]              csr_addr_i,
    input  logic [`EX_CNT_W-1:0]     cnt_i,
    input  logic                     dcache_addr_ok_i,
    input  logic                     dcache_miss_i,
    output logic                     pause_o,
    output logic                     branch_flush_o,
    output logic [`EX_XLEN-1:0]      branch_target_o,
    output logic [`EX_XLEN-1:0]      reg_write_data_o,
    output logic [`EX_XLEN-1:0]      mem_addr_o,
    output logic                     dcache_valid_o,
    output logic                     dcache_op_o,
    output logic [`EX_XLEN-1:0]      dcache_wdata_o,
    output logic [3:0]               dcache_wstrb_o,
    output logic                     exc_o,
    output ex_mem_pkg::exc_cause_e   exc_cause_o,
    output logic                     csr_we_o,
    output logic [13:0]              csr_waddr_o,
    output logic [`EX_XLEN-1:0]      csr_wdata_o
);

    import ex_op_pkg::*;
    import ex_mem_pkg::*;

    logic [`EX_XLEN-1:0] alu_res;
    logic [`EX_XLEN-1:0] quotient;
    logic [`EX_XLEN-1:0] remainder;
    logic [`EX_XLEN-1:0] div_res;
    logic [`EX_XLEN-1:0] link;
    logic [`EX_XLEN-1:0] csr_res;
    logic                div_done;
    logic                div_start;
    logic                is_div;
    logic                is_quo;
    logic                br_flush;
    logic                agu_valid;
    logic                agu_exc;
    logic                mem_stall;
    logic                ll_bit;
    exc_cause_e          agu_cause;

    assign ll_bit = csr_read_data_i[0];

    regular_alu u_regular_alu (
        .aluop_i  (aluop_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .imm_i    ({reg2_i[`EX_XLEN-1:12], 12'b0}),
        .result_o (alu_res)
    );

    assign is_div = aluop_i inside {ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU};
    assign is_quo = aluop_i inside {ALU_DIVW, ALU_DIVWU};
    // held until the divider reports done
    assign div_start = inst_valid_i && is_div && !div_done;

    div_alu u_div_alu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (div_start),
        .signed_i    (aluop_i inside {ALU_DIVW, ALU_MODW}),
        .dividend_i  (reg1_i),
        .divisor_i   (reg2_i),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .done_o      (div_done)
    );

    assign div_res = !div_done ? '0 : (is_quo ? quotient : remainder);

    branch_alu u_branch_alu (
        .aluop_i      (aluop_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .pre_taken_i  (pre_taken_i),
        .pre_target_i (pre_target_i),
        .taken_o      (),
        .target_o     (branch_target_o),
        .link_o       (link),
        .flush_o      (br_flush)
    );

    assign branch_flush_o = inst_valid_i && br_flush;

    mem_agu u_mem_agu (
        .aluop_i        (aluop_i),
        .reg1_i         (reg1_i),
        .reg2_i         (reg2_i),
        .inst_i         (inst_i),
        .ll_bit_i       (ll_bit),
        .addr_o         (mem_addr_o),
        .dcache_valid_o (agu_valid),
        .dcache_op_o    (dcache_op_o),
        .dcache_wdata_o (dcache_wdata_o),
        .dcache_wstrb_o (dcache_wstrb_o),
        .exc_o          (agu_exc),
        .exc_cause_o    (agu_cause)
    );

    assign dcache_valid_o = inst_valid_i && agu_valid;
    assign exc_o          = inst_valid_i && agu_exc;
    assign exc_cause_o    = exc_o ? agu_cause : EXC_NONE;
    assign mem_stall      = dcache_valid_o && dcache_miss_i && !dcache_addr_ok_i;
    assign pause_o        = div_start || mem_stall;

    always_comb begin
        case (aluop_i)
            ALU_CSRRD, ALU_CSRWR: csr_res = csr_read_data_i;
            ALU_RDCNTVLW:         csr_res = cnt_i[`EX_XLEN-1:0];
            ALU_RDCNTVHW:         csr_res = cnt_i[`EX_CNT_W-1:`EX_XLEN];
            default:              csr_res = '0;
        endcase
    end

    // LL bit is tracked through LLBCTL
    always_comb begin
        csr_we_o    = inst_valid_i && csr_write_en_i;
        csr_waddr_o = csr_addr_i;
        csr_wdata_o = reg1_i;
        if (aluop_i == ALU_LLW || (aluop_i == ALU_SCW && ll_bit)) begin
            csr_we_o    = inst_valid_i;
            csr_waddr_o = `EX_CSR_LLBCTL;
            csr_wdata_o = {{(`EX_XLEN-1){1'b0}}, aluop_i == ALU_LLW};
        end
    end

    always_comb begin
        case (alusel_i)
            SEL_LOGIC, SEL_SHIFT, SEL_ARITH: reg_write_data_o = alu_res;
            SEL_DIV:    reg_write_data_o = div_res;
            SEL_BRANCH: reg_write_data_o = link;
            SEL_LOAD_STORE: begin
                reg_write_data_o = {{(`EX_XLEN-1){1'b0}}, aluop_i == ALU_SCW && ll_bit};
            end
            SEL_CSR:    reg_write_data_o = csr_res;
            default:    reg_write_data_o = '0;
        endcase
    end

endmodule

// File: source/mem_agu.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module mem_agu (
    input  ex_op_pkg::alu_op_e       aluop_i,
    input  logic [`EX_XLEN-1:0]      reg1_i,
    input  logic [`EX_XLEN-1:0]      reg2_i,
    input  logic [`EX_XLEN-1:0]      inst_i,
    input  logic                     ll_bit_i,
    output logic [`EX_XLEN-1:0]      addr_o,
    output logic                     dcache_valid_o,
    output logic                     dcache_op_o,
    output logic [`EX_XLEN-1:0]      dcache_wdata_o,
    output logic [3:0]               dcache_wstrb_o,
    output logic                     exc_o,
    output ex_mem_pkg::exc_cause_e   exc_cause_o
);

    import ex_op_pkg::*;
    import ex_mem_pkg::*;

    mem_size_e size;
    logic      is_load;
    logic      is_store;
    logic      misalign;
    logic      sc_fail;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = SIZE_WORD;
        case (aluop_i)
            ALU_LDB, ALU_LDBU: begin
                is_load = 1'b1;
                size    = SIZE_BYTE;
            end
            ALU_LDH, ALU_LDHU: begin
                is_load = 1'b1;
                size    = SIZE_HALF;
            end
            ALU_LDW, ALU_LLW: is_load = 1'b1;
            ALU_STB: begin
                is_store = 1'b1;
                size     = SIZE_BYTE;
            end
            ALU_STH: begin
                is_store = 1'b1;
                size     = SIZE_HALF;
            end
            ALU_STW, ALU_SCW: is_store = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        if (is_load) begin
            addr_o = reg1_i + reg2_i;
        end else if (aluop_i == ALU_SCW) begin
            // si14 counts words
            addr_o = reg1_i + {{(`EX_XLEN-16){inst_i[23]}}, inst_i[23:10], 2'b00};
        end else if (is_store) begin
            addr_o = reg1_i + {{(`EX_XLEN-12){inst_i[21]}}, inst_i[21:10]};
        end else begin
            addr_o = '0;
        end
    end

    assign misalign = (is_load || is_store) &&
                      ((size == SIZE_HALF && addr_o[0]) ||
                       (size == SIZE_WORD && addr_o[1:0] != 2'b00));
    assign sc_fail  = (aluop_i == ALU_SCW) && !ll_bit_i;

    assign exc_o          = misalign;
    assign exc_cause_o    = misalign ? EXC_ALE : EXC_NONE;
    assign dcache_valid_o = (is_load || is_store) && !misalign && !sc_fail;
    assign dcache_op_o    = is_store && !sc_fail;

    // store lanes replicate the low bits across the word
    always_comb begin
        dcache_wdata_o = '0;
        dcache_wstrb_o = 4'b1111;
        if (is_store && !sc_fail) begin
            case (size)
                SIZE_BYTE: begin
                    dcache_wdata_o = {4{reg2_i[7:0]}};
                    dcache_wstrb_o = 4'b0001 << addr_o[1:0];
                end
                SIZE_HALF: begin
                    dcache_wdata_o = {2{reg2_i[15:0]}};
                    dcache_wstrb_o = addr_o[1] ? 4'b1100 : 4'b0011;
                end
                default: dcache_wdata_o = reg2_i;
            endcase
        end
    end

endmodule

// File: source/regular_alu.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module regular_alu (
    input  ex_op_pkg::alu_op_e   aluop_i,
    input  logic [`EX_XLEN-1:0]  reg1_i,
    input  logic [`EX_XLEN-1:0]  reg2_i,
    input  logic [`EX_XLEN-1:0]  imm_i,
    output logic [`EX_XLEN-1:0]  result_o
);

    import ex_op_pkg::*;

    localparam int SHAMT_W = $clog2(`EX_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [`EX_XLEN-1:0] sum;
    logic [`EX_XLEN-1:0] diff;

    assign shamt = reg2_i[SHAMT_W-1:0];
    assign sum   = reg1_i + reg2_i;
    assign diff  = reg1_i - reg2_i;

    always_comb begin
        case (aluop_i)
            ALU_ADD:   result_o = sum;
            ALU_SUB:   result_o = diff;
            ALU_SLT: begin
                result_o = {{(`EX_XLEN-1){1'b0}}, $signed(reg1_i) < $signed(reg2_i)};
            end
            ALU_SLTU: begin
                result_o = {{(`EX_XLEN-1){1'b0}}, reg1_i < reg2_i};
            end
            ALU_AND:   result_o = reg1_i & reg2_i;
            ALU_OR:    result_o = reg1_i | reg2_i;
            ALU_NOR:   result_o = ~(reg1_i | reg2_i);
            ALU_XOR:   result_o = reg1_i ^ reg2_i;
            ALU_SLL:   result_o = reg1_i << shamt;
            ALU_SRL:   result_o = reg1_i >> shamt;
            ALU_SRA:   result_o = $unsigned($signed(reg1_i) >>> shamt);
            // upper immediate with low bits already zero
            ALU_LU12I: result_o = imm_i;
            default:   result_o = '0;
        endcase
    end

endmodule

// File: tb/ex_stage_chk.sv
`timescale 1ns/100ps

module ex_stage_chk (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  ex_op_pkg::alu_op_e   aluop_i,
    input  logic                 pause_i,
    input  logic                 dcache_valid_i,
    input  logic                 exc_i,
    input  logic [3:0]           dcache_wstrb_i
);

    import ex_op_pkg::*;

    logic is_div;
    logic is_mem;

    assign is_div = aluop_i inside {ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU};
    assign is_mem = aluop_i inside {ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW, ALU_LLW,
                                    ALU_STB, ALU_STH, ALU_STW, ALU_SCW};

    no_req_with_exc: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(dcache_valid_i && exc_i))
        else $error("dcache request issued together with an exception");

    byte_strb_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dcache_valid_i && aluop_i == ALU_STB) |-> $onehot(dcache_wstrb_i))
        else $error("byte store strobe is not one-hot");

    // 33 stall cycles plus one of slack
    div_pause_bounded: assert property (@(posedge clk) disable iff (!rst_n_i)
        (is_div && $rose(pause_i)) |-> ##[1:34] !pause_i)
        else $error("divide stall lasted longer than 34 cycles");

    stall_needs_source: assert property (@(posedge clk) disable iff (!rst_n_i)
        pause_i |-> (is_div || is_mem))
        else $error("pause raised without a divide or memory opcode");

endmodule

bind ex_stage ex_stage_chk chk_i (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .aluop_i        (aluop_i),
    .pause_i        (pause_o),
    .dcache_valid_i (dcache_valid_o),
    .exc_i          (exc_o),
    .dcache_wstrb_i (dcache_wstrb_o)
);

// File: tb/ex_stage_tb.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage_tb;

    import ex_op_pkg::*;
    import ex_mem_pkg::*;

    localparam int TIMEOUT = 100;

    logic                  clk;
    logic                  rst_n_i;
    logic                  inst_valid_i;
    logic [`EX_XLEN-1:0]   pc_i;
    logic [`EX_XLEN-1:0]   inst_i;
    alu_op_e               aluop_i;
    alu_sel_e              alusel_i;
    logic [`EX_XLEN-1:0]   reg1_i;
    logic [`EX_XLEN-1:0]   reg2_i;
    logic                  pre_taken_i;
    logic [`EX_XLEN-1:0]   pre_target_i;
    logic [`EX_XLEN-1:0]   csr_read_data_i;
    logic                  csr_write_en_i;
    logic [13:0]           csr_addr_i;
    logic [`EX_CNT_W-1:0]  cnt_i;
    logic                  dcache_addr_ok_i;
    logic                  dcache_miss_i;
    logic                  pause_o;
    logic                  branch_flush_o;
    logic [`EX_XLEN-1:0]   branch_target_o;
    logic [`EX_XLEN-1:0]   reg_write_data_o;
    logic [`EX_XLEN-1:0]   mem_addr_o;
    logic                  dcache_valid_o;
    logic                  dcache_op_o;
    logic [`EX_XLEN-1:0]   dcache_wdata_o;
    logic [3:0]            dcache_wstrb_o;
    logic                  exc_o;
    exc_cause_e            exc_cause_o;
    logic                  csr_we_o;
    logic [13:0]           csr_waddr_o;
    logic [`EX_XLEN-1:0]   csr_wdata_o;

    // stimulus and expected values of the current vector
    logic [5:0]            v_op;
    logic [2:0]            v_sel;
    logic [`EX_XLEN-1:0]   v_pc;
    logic [`EX_XLEN-1:0]   v_inst;
    logic [`EX_XLEN-1:0]   v_reg1;
    logic [`EX_XLEN-1:0]   v_reg2;
    logic                  v_pt;
    logic [`EX_XLEN-1:0]   v_ptgt;
    logic [`EX_XLEN-1:0]   v_csr;
    logic [`EX_CNT_W-1:0]  v_cnt;
    logic [`EX_XLEN-1:0]   e_wdata;
    logic                  e_flush;
    logic [`EX_XLEN-1:0]   e_target;
    logic [`EX_XLEN-1:0]   e_addr;
    logic [3:0]            e_strb;
    logic [6:0]            v_cause;
    logic [1:0]            v_mode;

    int seed;
    int fd;

    ex_stage dut_i (.*);

    always #10 clk = ~clk;

    task automatic fail_and_stop(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [`EX_XLEN-1:0] exp,
                              input logic [`EX_XLEN-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_and_stop("wrong value on a DUT output");
        end
    endtask

    task automatic check_strb(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_and_stop("wrong value on a DUT output");
        end
    endtask

    task automatic check_cause(input string name, input exc_cause_e exp, input exc_cause_e act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_and_stop("wrong value on a DUT output");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_and_stop("wrong value on a DUT output");
        end
    endtask

    task automatic check_csr_addr(input string name, input logic [13:0] exp,
                                  input logic [13:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_and_stop("wrong value on a DUT output");
        end
    endtask

    task automatic drive_bubble();
        inst_valid_i     = 1'b0;
        pc_i             = '0;
        inst_i           = '0;
        aluop_i          = ALU_NOP;
        alusel_i         = SEL_NONE;
        reg1_i           = '0;
        reg2_i           = '0;
        pre_taken_i      = 1'b0;
        pre_target_i     = '0;
        csr_read_data_i  = '0;
        csr_write_en_i   = 1'b0;
        csr_addr_i       = '0;
        cnt_i            = '0;
        dcache_addr_ok_i = 1'b1;
        dcache_miss_i    = 1'b0;
    endtask

    task automatic drive_vector(input logic miss);
        inst_valid_i     = 1'b1;
        pc_i             = v_pc;
        inst_i           = v_inst;
        aluop_i          = alu_op_e'(v_op);
        alusel_i         = alu_sel_e'(v_sel);
        reg1_i           = v_reg1;
        reg2_i           = v_reg2;
        pre_taken_i      = v_pt;
        pre_target_i     = v_ptgt;
        csr_read_data_i  = v_csr;
        cnt_i            = v_cnt;
        dcache_miss_i    = miss;
        dcache_addr_ok_i = !miss;
    endtask

    // samples at the falling edge and counts cycles until pause_o is low
    task automatic wait_pause_low(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_and_stop("timeout: pause_o did not fall within 100 cycles");
            end
        end while (pause_o);
    endtask

    task automatic check_outputs();
        logic                is_store;
        logic                is_mem;
        logic                exp_valid;
        logic                exp_we;
        logic [`EX_XLEN-1:0] exp_wdata;
        is_store  = aluop_i inside {ALU_STB, ALU_STH, ALU_STW, ALU_SCW};
        is_mem    = is_store ||
                    (aluop_i inside {ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW, ALU_LLW});
        // failed sc issues nothing
        exp_valid = is_mem && (v_cause == EXC_NONE) && !(aluop_i == ALU_SCW && !v_csr[0]);
        exp_we    = (aluop_i == ALU_LLW) || (aluop_i == ALU_SCW && v_csr[0]);
        check_word("reg_write_data_o", e_wdata, reg_write_data_o);
        check_flag("branch_flush_o", e_flush, branch_flush_o);
        check_word("branch_target_o", e_target, branch_target_o);
        check_word("mem_addr_o", e_addr, mem_addr_o);
        check_strb("dcache_wstrb_o", e_strb, dcache_wstrb_o);
        check_cause("exc_cause_o", exc_cause_e'(v_cause), exc_cause_o);
        check_flag("exc_o", v_cause != EXC_NONE, exc_o);
        check_flag("dcache_valid_o", exp_valid, dcache_valid_o);
        check_flag("csr_we_o", exp_we, csr_we_o);
        if (exp_we) begin
            check_csr_addr("csr_waddr_o", `EX_CSR_LLBCTL, csr_waddr_o);
            check_word("csr_wdata_o", `EX_XLEN'(aluop_i == ALU_LLW), csr_wdata_o);
        end
        if (exp_valid) begin
            // loads read, stores write
            check_flag("dcache_op_o", is_store, dcache_op_o);
        end
        if (exp_valid && is_store) begin
            case (aluop_i)
                ALU_STB: exp_wdata = {4{reg2_i[7:0]}};
                ALU_STH: exp_wdata = {2{reg2_i[15:0]}};
                default: exp_wdata = reg2_i;
            endcase
            check_word("dcache_wdata_o", exp_wdata, dcache_wdata_o);
        end
    endtask

    initial begin
        string line;
        int    n;
        int    cycles;
        int    stall;
        int    vectors;
        seed    = 94392;
        vectors = 0;
        clk     = 1'b0;
        rst_n_i = 1'b0;
        drive_bubble();
        repeat (2) @(negedge clk);
        rst_n_i = 1'b1;

        fd = $fopen("tb/ex_testdata.txt", "r");
        if (fd == 0) begin
            fail_and_stop("could not open tb/ex_testdata.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_op, v_sel, v_pc, v_inst, v_reg1, v_reg2, v_pt, v_ptgt, v_csr,
                        v_cnt, e_wdata, e_flush, e_target, e_addr, e_strb, v_cause, v_mode);
            if (n != 17) begin
                fail_and_stop("malformed line in tb/ex_testdata.txt");
            end
            vectors++;
            drive_vector(v_mode == 2'd2);
            if (v_mode == 2'd1) begin
                // divide holds pause_o until the done cycle
                wait_pause_low(cycles);
                check_word("pause_o cycles", `EX_XLEN'(33), `EX_XLEN'(cycles));
                check_outputs();
            end else if (v_mode == 2'd2) begin
                stall = 1 + ($unsigned($random(seed)) % 6);
                repeat (stall) begin
                    @(negedge clk);
                    check_flag("pause_o", 1'b1, pause_o);
                    check_outputs();
                end
                dcache_miss_i    = 1'b0;
                dcache_addr_ok_i = 1'b1;
                wait_pause_low(cycles);
                check_outputs();
            end else begin
                @(negedge clk);
                check_flag("pause_o", 1'b0, pause_o);
                check_outputs();
            end
            // idle cycle lets the divider return to idle
            drive_bubble();
            @(negedge clk);
        end
        $fclose(fd);

        if (vectors == 0) begin
            $display("no vectors found in tb/ex_testdata.txt");
            $display("Test failed");
            $fatal(1);
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: tb/ex_testdata.txt
# op sel pc inst reg1 reg2 pre_taken pre_target csr_rdata cnt
# expected: wdata flush target mem_addr wstrb exc_cause mode (0 plain, 1 divide, 2 cache miss)
01 2 1c000000 00000000 00000005 00000007 0 00000000 00000000 0 0000000c 0 1c000004 00000000 f 00 0
02 2 1c000004 00000000 00000003 00000005 0 00000000 00000000 0 fffffffe 0 1c000008 00000000 f 00 0
03 2 1c000008 00000000 ffffffff 00000001 0 00000000 00000000 0 00000001 0 1c00000c 00000000 f 00 0
04 2 1c00000c 00000000 ffffffff 00000001 0 00000000 00000000 0 00000000 0 1c000010 00000000 f 00 0
07 0 1c000010 00000000 f0f0f0f0 0f0f0000 0 00000000 00000000 0 00000f0f 0 1c000014 00000000 f 00 0
0b 1 1c000014 00000000 80000000 00000004 0 00000000 00000000 0 f8000000 0 1c000018 00000000 f 00 0
09 1 1c000018 00000000 00000001 0000003f 0 00000000 00000000 0 80000000 0 1c00001c 00000000 f 00 0
0c 2 1c00001c 00000000 00000000 12345abc 0 00000000 00000000 0 12345000 0 1c000020 00000000 f 00 0
30 6 1c000020 00000000 00000000 00000000 0 00000000 0000abcd 0 0000abcd 0 1c000024 00000000 f 00 0
33 6 1c000024 00000000 00000000 00000000 0 00000000 00000000 0123456789abcdef 01234567 0 1c000028 00000000 f 00 0
32 6 1c000028 00000000 00000000 00000000 0 00000000 00000000 0123456789abcdef 89abcdef 0 1c00002c 00000000 f 00 0
10 3 1c000030 00000000 fffffff9 00000002 0 00000000 00000000 0 fffffffd 0 1c000034 00000000 f 00 1
11 3 1c000034 00000000 fffffff9 00000002 0 00000000 00000000 0 ffffffff 0 1c000038 00000000 f 00 1
12 3 1c000038 00000000 00000064 00000007 0 00000000 00000000 0 0000000e 0 1c00003c 00000000 f 00 1
13 3 1c00003c 00000000 00000064 00000007 0 00000000 00000000 0 00000002 0 1c000040 00000000 f 00 1
10 3 1c000040 00000000 00000007 fffffffe 0 00000000 00000000 0 fffffffd 0 1c000044 00000000 f 00 1
11 3 1c000044 00000000 00000007 fffffffe 0 00000000 00000000 0 00000001 0 1c000048 00000000 f 00 1
10 3 1c000048 00000000 00001234 00000000 0 00000000 00000000 0 ffffffff 0 1c00004c 00000000 f 00 1
13 3 1c00004c 00000000 00001234 00000000 0 00000000 00000000 0 00001234 0 1c000050 00000000 f 00 1
18 4 1c000100 00004000 00000005 00000005 0 00000000 00000000 0 1c000104 1 1c000140 00000000 f 00 0
19 4 1c000110 00004000 00000005 00000005 1 1c000150 00000000 0 1c000114 1 1c000114 00000000 f 00 0
1a 4 1c000120 03fff000 ffffffff 00000001 1 1c000110 00000000 0 1c000124 0 1c000110 00000000 f 00 0
1d 4 1c000130 00004000 ffffffff 00000001 1 1c000180 00000000 0 1c000134 1 1c000170 00000000 f 00 0
1c 4 1c000140 00004000 ffffffff 00000001 0 00000000 00000000 0 1c000144 0 1c000144 00000000 f 00 0
1e 4 1c000150 00000400 1c002000 00000000 0 00000000 00000000 0 1c000154 1 1c002004 00000000 f 00 0
1f 4 1c000160 00040000 00000000 00000000 1 1c000560 00000000 0 1c000164 0 1c000560 00000000 f 00 0
1b 4 1c000170 00004000 ffffffff 00000001 0 00000000 00000000 0 1c000174 0 1c000174 00000000 f 00 0
20 5 1c000200 00000000 00001000 00000003 0 00000000 00000000 0 00000000 0 1c000204 00001003 f 00 0
22 5 1c000204 00000000 00001000 00000001 0 00000000 00000000 0 00000000 0 1c000208 00001001 f 09 0
24 5 1c000208 00000000 00001000 00000008 0 00000000 00000000 0 00000000 0 1c00020c 00001008 f 00 0
24 5 1c00020c 00000000 00001000 00000002 0 00000000 00000000 0 00000000 0 1c000210 00001002 f 09 0
28 5 1c000210 00001400 00002000 000000a5 0 00000000 00000000 0 00000000 0 1c000214 00002005 2 00 0
29 5 1c000214 00000800 00002000 0000beef 0 00000000 00000000 0 00000000 0 1c000218 00002002 c 00 0
29 5 1c000218 00000c00 00002000 0000beef 0 00000000 00000000 0 00000000 0 1c00021c 00002003 c 09 0
2a 5 1c00021c 003ff000 00002000 12345678 0 00000000 00000000 0 00000000 0 1c000220 00001ffc f 00 0
2a 5 1c000220 00000400 00002000 12345678 0 00000000 00000000 0 00000000 0 1c000224 00002001 f 09 0
25 5 1c000224 00000000 00003000 00000004 0 00000000 00000000 0 00000000 0 1c000228 00003004 f 00 0
2b 5 1c000228 00000800 00003000 cafef00d 0 00000000 00000001 0 00000001 0 1c00022c 00003008 f 00 0
2b 5 1c00022c 00000800 00003000 cafef00d 0 00000000 00000000 0 00000000 0 1c000230 00003008 f 00 0
24 5 1c000230 00000000 00004000 00000000 0 00000000 00000000 0 00000000 0 1c000234 00004000 f 00 2
28 5 1c000234 00000400 00004000 0000005a 0 00000000 00000000 0 00000000 0 1c000238 00004001 2 00 2
